// File: src/payload_fifo.sv
`timescale 1ns/1ps

module payload_fifo import udp_echo_pkg::*; (
    input  logic          clk,
    input  logic          rst,

    // Write side
    input  logic          in_valid,
    output logic          in_ready,
    input  payload_beat_t in_beat,

    // Read side
    output logic          out_valid,
    input  logic          out_ready,
    output payload_beat_t out_beat
);

    payload_beat_t mem [0:(1 << fifo_addr_width) - 1];

    // Extra MSB tells full from empty
    logic [fifo_addr_width:0] wr_ptr;
    logic [fifo_addr_width:0] rd_ptr;

    logic empty;
    logic full;
    logic stage_load;
    logic bypass;
    logic write_en;

    assign empty = wr_ptr == rd_ptr;
    assign full  = (wr_ptr[fifo_addr_width] != rd_ptr[fifo_addr_width]) &&
                   (wr_ptr[fifo_addr_width-1:0] == rd_ptr[fifo_addr_width-1:0]);

    assign in_ready = !full;

    // Output register can take a new beat
    assign stage_load = !out_valid || out_ready;

    // Storage empty, so an incoming beat goes straight to the output register
    assign bypass   = empty && stage_load;
    assign write_en = in_valid && in_ready && !bypass;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (write_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (stage_load) begin
                if (!empty) begin
                    rd_ptr    <= rd_ptr + 1'b1;
                    out_valid <= 1'b1;
                end else begin
                    out_valid <= in_valid;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[wr_ptr[fifo_addr_width-1:0]] <= in_beat;
        end
    end

    // Output stage holds its beat while the sink stalls
    always_ff @(posedge clk) begin
        if (stage_load) begin
            if (!empty) begin
                out_beat <= mem[rd_ptr[fifo_addr_width-1:0]];
            end else if (in_valid) begin
                out_beat <= in_beat;
            end
        end
    end

endmodule

// File: src/udp_echo.sv
`timescale 1ns/1ps

module udp_echo import udp_echo_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    // Received UDP frames
    input  logic                 in_hdr_valid,
    output logic                 in_hdr_ready,
    input  udp_rx_hdr_t          in_hdr,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  payload_beat_t        in_beat,

    // Echo replies
    output logic                 out_hdr_valid,
    input  logic                 out_hdr_ready,
    output udp_tx_hdr_t          out_hdr,
    output logic                 out_valid,
    input  logic                 out_ready,
    output payload_beat_t        out_beat,

    output logic [led_width-1:0] led
);

    logic          fifo_valid;
    logic          fifo_ready;
    payload_beat_t fifo_beat;

    logic          valid_last;

    udp_echo_filter u_filter (
        .clk           (clk),
        .rst           (rst),
        .in_hdr_valid  (in_hdr_valid),
        .in_hdr_ready  (in_hdr_ready),
        .in_hdr        (in_hdr),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_beat       (in_beat),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready),
        .out_hdr       (out_hdr),
        .fifo_valid    (fifo_valid),
        .fifo_ready    (fifo_ready),
        .fifo_beat     (fifo_beat)
    );

    payload_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fifo_valid),
        .in_ready  (fifo_ready),
        .in_beat   (fifo_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

    // Show first payload byte after each idle gap on the reply stream
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_last <= 1'b0;
            led        <= '0;
        end else begin
            valid_last <= out_valid;
            if (out_valid && !valid_last) begin
                led <= out_beat.data[led_width-1:0];
            end
        end
    end

endmodule

// File: src/udp_echo_filter.sv
`timescale 1ns/1ps

module udp_echo_filter import udp_echo_pkg::*; (
    input  logic          clk,
    input  logic          rst,

    // Received header
    input  logic          in_hdr_valid,
    output logic          in_hdr_ready,
    input  udp_rx_hdr_t   in_hdr,

    // Received payload
    input  logic          in_valid,
    output logic          in_ready,
    input  payload_beat_t in_beat,

    // Reply header
    output logic          out_hdr_valid,
    input  logic          out_hdr_ready,
    output udp_tx_hdr_t   out_hdr,

    // Payload towards the FIFO
    output logic          fifo_valid,
    input  logic          fifo_ready,
    output payload_beat_t fifo_beat
);

    logic port_match;
    logic port_miss;

    // Per-frame payload routing state
    logic match_reg;
    logic drop_reg;
    logic frame_start;
    logic last_taken;

    assign port_match = in_hdr.dest_port == echo_port;
    assign port_miss  = !port_match;

    // Header path

    // Only matching headers are passed on, the rest are consumed here
    assign out_hdr_valid = in_hdr_valid && port_match;
    assign in_hdr_ready  = (out_hdr_ready && port_match) || port_miss;

    always_comb begin
        out_hdr              = '0;
        out_hdr.ip_dscp      = 6'd0;
        out_hdr.ip_ecn       = 2'd0;
        out_hdr.ip_ttl       = reply_ttl;
        out_hdr.ip_source_ip = local_ip;
        // Reply goes back to the sender
        out_hdr.ip_dest_ip   = in_hdr.source_ip;
        out_hdr.source_port  = in_hdr.dest_port;
        out_hdr.dest_port    = in_hdr.source_port;
        out_hdr.length       = in_hdr.length;
        // No UDP checksum on replies
        out_hdr.checksum     = 16'd0;
    end

    // Payload path

    // Idle flags mean no frame decision has been taken yet
    assign frame_start = !match_reg && !drop_reg;
    assign last_taken  = in_valid && in_ready && in_beat.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            match_reg <= 1'b0;
            drop_reg  <= 1'b0;
        end else if (in_valid) begin
            // Decide at frame start and again right after each last beat
            if (frame_start || last_taken) begin
                match_reg <= port_match;
                drop_reg  <= port_miss;
            end
        end else begin
            match_reg <= 1'b0;
            drop_reg  <= 1'b0;
        end
    end

    // Matched frames go into the FIFO, dropped frames are sunk here
    assign fifo_valid = in_valid && match_reg;
    assign in_ready   = (fifo_ready && match_reg) || drop_reg;
    assign fifo_beat  = in_beat;

endmodule

// File: src/udp_echo_pkg.sv
package udp_echo_pkg;

    // Echo service configuration
    localparam logic [15:0] echo_port = 16'd1234;
    localparam logic [31:0] local_ip  = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [7:0]  reply_ttl = 8'd64;

    // Payload stream widths
    localparam int data_width = 64;
    localparam int keep_width = 8;

    // 1024 beats of payload buffering
    localparam int fifo_addr_width = 10;

    localparam int led_width = 8;

    // Header as delivered by the UDP stack
    typedef struct packed {
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_rx_hdr_t;

    // Header handed back to the UDP stack for transmit
    typedef struct packed {
        logic [5:0]  ip_dscp;
        logic [1:0]  ip_ecn;
        logic [7:0]  ip_ttl;
        logic [31:0] ip_source_ip;
        logic [31:0] ip_dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_tx_hdr_t;

    // One beat of the payload stream
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [keep_width-1:0] keep;
        logic                  last;
        logic                  user;
    } payload_beat_t;

endpackage

// File: tests/udp_echo_chk.sv
`timescale 1ns/1ps

module udp_echo_chk import udp_echo_pkg::*; (
    input logic                 clk,
    input logic                 rst,
    input logic                 in_hdr_valid,
    input logic                 out_hdr_valid,
    input udp_tx_hdr_t          out_hdr,
    input logic                 out_valid,
    input logic                 out_ready,
    input payload_beat_t        out_beat,
    input logic [led_width-1:0] led
);

    int fail_count = 0;

    // Stalled reply beat stays put
    beat_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else begin
            fail_count = fail_count + 1;
            $error("Reply beat changed or vanished while the sink stalled");
        end

    // Reply headers only for a received header aimed at the echo port
    hdr_port: assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid |-> in_hdr_valid && out_hdr.source_port == echo_port)
        else begin
            fail_count = fail_count + 1;
            $error("Reply header offered for a port other than the echo port");
        end

    reset_idle: assert property (@(posedge clk)
        rst |=> !out_valid && !out_hdr_valid && led == '0)
        else begin
            fail_count = fail_count + 1;
            $error("Outputs not idle in the cycle after reset");
        end

endmodule

// File: tests/udp_echo_vectors.svh
`ifndef UDP_ECHO_VECTORS_SVH
`define UDP_ECHO_VECTORS_SVH

// out_ready behavior while a row runs
localparam int ready_always = 0;
localparam int ready_lfsr   = 1;
// Low for half the beat count in cycles, then high
localparam int ready_hold   = 2;

typedef struct {
    string       name;
    logic [15:0] dest_port;
    logic [15:0] source_port;
    logic [31:0] source_ip;
    int          beats;
    logic [63:0] start;
    int          ready_mode;
    bit          echo;
} frame_row_t;

localparam int num_rows = 7;

// Columns: name, dest_port, source_port, source_ip, beat count,
// payload start value, out_ready mode, expected echo
frame_row_t rows [num_rows] = '{
    '{"echo_single", 16'd1234, 16'd5000, 32'h0a00_0005, 1, 64'h11, ready_always, 1'b1},
    '{"echo_basic", 16'd1234, 16'd4321, 32'h0a00_0007, 8, 64'h0123_4567_89ab_cd00,
      ready_always, 1'b1},
    '{"drop_port", 16'd1235, 16'd4321, 32'h0a00_0007, 6, 64'h5500, ready_always, 1'b0},
    '{"echo_random", 16'd1234, 16'd777, 32'hac10_0309, 40, 64'hfeed_0000_0000_00a0,
      ready_lfsr, 1'b1},
    '{"drop_zero", 16'd0, 16'd1234, 32'hc0a8_0102, 3, 64'h77, ready_lfsr, 1'b0},
    '{"echo_after_drop", 16'd1234, 16'd9, 32'hc0a8_0103, 5, 64'h3c, ready_lfsr, 1'b1},
    '{"echo_long", 16'd1234, 16'd2000, 32'h0a01_0203, 2400, 64'h1000, ready_hold, 1'b1}
};

`endif

// File: tests/udp_echo_tb.sv
`timescale 1ns/1ps

module udp_echo_tb import udp_echo_pkg::*; ();

    `include "udp_echo_vectors.svh"

    logic                 clk;
    logic                 rst;
    logic                 in_hdr_valid;
    logic                 in_hdr_ready;
    udp_rx_hdr_t          in_hdr;
    logic                 in_valid;
    logic                 in_ready;
    payload_beat_t        in_beat;
    logic                 out_hdr_valid;
    logic                 out_hdr_ready;
    udp_tx_hdr_t          out_hdr;
    logic                 out_valid;
    logic                 out_ready;
    payload_beat_t        out_beat;
    logic [led_width-1:0] led;

    udp_tx_hdr_t   hdr_q [$];
    payload_beat_t beat_q [$];
    int            ready_mode = ready_always;
    int            hold_left = 0;
    int            beats_sent = 0;
    bit            stall_seen = 1'b0;
    logic [31:0]   lfsr_state = 32'h8c2f_504a;
    int            cycles = 0;
    int            cycle_limit = 0;

    udp_echo u_udp_echo (.*);

    bind udp_echo udp_echo_chk u_chk (
        .clk           (clk),
        .rst           (rst),
        .in_hdr_valid  (in_hdr_valid),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr       (out_hdr),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_beat      (out_beat),
        .led           (led)
    );

    always #20 clk = !clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Beat k carries start + k, short keep and start-dependent user on the last beat
    function automatic payload_beat_t make_beat(input int r, input int k);
        payload_beat_t b;
        b.data = rows[r].start + 64'(k);
        b.last = k == rows[r].beats - 1;
        b.keep = b.last ? 8'h0f : 8'hff;
        b.user = b.last && rows[r].start[0];
        return b;
    endfunction

    task automatic check_value(input string test, input string item,
                               input logic [159:0] expected, input logic [159:0] actual);
        if (expected !== actual) begin
            $display("Error in %s: %s expected %0h, actual %0h", test, item, expected, actual);
            $display("Finished with errors");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Sink side of the reply stream
    always begin
        @(posedge clk);
        #2;
        case (ready_mode)
            ready_lfsr: begin
                out_ready = lfsr_state[0];
                lfsr_state = lfsr_next(lfsr_state);
            end
            ready_hold: begin
                out_ready = hold_left == 0;
                if (hold_left > 0) begin
                    hold_left = hold_left - 1;
                end
            end
            default: out_ready = 1'b1;
        endcase
    end

    // Monitor samples mid-cycle where everything is settled
    always @(negedge clk) begin
        if (!rst) begin
            if (out_hdr_valid && out_hdr_ready) begin
                hdr_q.push_back(out_hdr);
            end
            if (out_valid && out_ready) begin
                beat_q.push_back(out_beat);
            end
            // First cycle of a frame is always a stall, so skip it
            if (in_valid && !in_ready && beats_sent > 0) begin
                stall_seen = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not complete within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic drive_frame(input int r);
        logic taken;
        in_hdr.source_ip   = rows[r].source_ip;
        in_hdr.dest_ip     = local_ip;
        in_hdr.source_port = rows[r].source_port;
        in_hdr.dest_port   = rows[r].dest_port;
        in_hdr.length      = 16'(8 + 8 * rows[r].beats);
        in_hdr.checksum    = 16'hbeef;
        in_hdr_valid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_hdr_ready;
            @(posedge clk);
            #2;
        end
        in_hdr_valid = 1'b0;
        beats_sent = 0;
        while (beats_sent < rows[r].beats) begin
            in_valid = 1'b1;
            in_beat = make_beat(r, beats_sent);
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #2;
            if (taken) begin
                beats_sent = beats_sent + 1;
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 4) begin
            @(negedge clk);
            quiet = out_valid ? 0 : quiet + 1;
        end
    endtask

    task automatic run_row(input int r);
        logic [led_width-1:0] led_before;
        udp_tx_hdr_t          exp_hdr;
        int                   n;
        @(negedge clk);
        ready_mode = rows[r].ready_mode;
        hold_left = rows[r].beats / 2;
        stall_seen = 1'b0;
        led_before = led;
        hdr_q.delete();
        beat_q.delete();
        @(posedge clk);
        #2;
        drive_frame(r);
        wait_idle();
        n = rows[r].echo ? rows[r].beats : 0;
        check_value(rows[r].name, "header count", rows[r].echo, hdr_q.size());
        if (rows[r].echo) begin
            exp_hdr = '0;
            exp_hdr.ip_ttl       = reply_ttl;
            exp_hdr.ip_source_ip = local_ip;
            exp_hdr.ip_dest_ip   = rows[r].source_ip;
            exp_hdr.source_port  = rows[r].dest_port;
            exp_hdr.dest_port    = rows[r].source_port;
            exp_hdr.length       = 16'(8 + 8 * rows[r].beats);
            check_value(rows[r].name, "reply header", exp_hdr, hdr_q[0]);
        end
        check_value(rows[r].name, "beat count", n, beat_q.size());
        for (int k = 0; k < n; k++) begin
            check_value(rows[r].name, $sformatf("beat %0d", k), make_beat(r, k), beat_q[k]);
        end
        check_value(rows[r].name, "led",
                    rows[r].echo ? rows[r].start[led_width-1:0] : led_before, led);
        check_value(rows[r].name, "input stall", rows[r].ready_mode == ready_hold, stall_seen);
    endtask

    initial begin
        int total;
        total = 0;
        clk = 1'b0;
        rst = 1'b1;
        in_hdr_valid = 1'b0;
        in_hdr = '0;
        in_valid = 1'b0;
        in_beat = '0;
        out_hdr_ready = 1'b1;
        out_ready = 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            total = total + rows[r].beats;
        end
        cycle_limit = total * 4 + 200;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_value("reset", "out_valid", 0, out_valid);
        check_value("reset", "out_hdr_valid", 0, out_hdr_valid);
        check_value("reset", "in_ready", 0, in_ready);
        check_value("reset", "led", 0, led);
        repeat (2) @(posedge clk);
        #2;
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        if (u_udp_echo.u_chk.fail_count != 0) begin
            $display("Assertion failures: %0d", u_udp_echo.u_chk.fail_count);
            $display("Finished with errors");
            $fatal(1, "Bound assertions failed");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: udp_echo.f
+incdir+tests
src/udp_echo_pkg.sv
src/udp_echo_filter.sv
src/payload_fifo.sv
src/udp_echo.sv
tests/udp_echo_chk.sv
tests/udp_echo_tb.sv
